//--- cic.f
common/cic_pkg.sv
src/cic_pin_sync.sv
cic/cic_timer.sv
cic/cic_ram.sv
cic/cic_regs.sv
cic/cic_core.sv
testbench/cic_checker.sv
testbench/tb_cic.sv

//--- Makefile
# Verilator build and run for the cic_core testbench

VERILATOR ?= verilator
TOP       ?= tb_cic
FILELIST  ?= cic.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_TEXT ?= *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '$(PASS_TEXT)'

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- testbench/tb_cic.sv
`timescale 1ns/100ps

module tb_cic;

    import cic_pkg::*;

    typedef enum logic [2:0] {
        OP_WRITE, OP_READ, OP_IREAD, OP_PINS, OP_EDGES, OP_WAIT, OP_CHECK, OP_RESET
    } op_t;

    typedef struct packed {
        op_t         op;
        logic [31:0] addr;
        logic [31:0] data;      // write data, count or check kind
        logic [3:0]  mask;
        logic [3:0]  pins;      // reset, cic clk, dq pulled low, si clk
        logic [31:0] exp_value;
    } step_t;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic [31:0] ibus_addr = 32'd0;
    logic        ibus_cyc = 1'b0;
    logic [31:0] ibus_rdata;
    logic        ibus_ack;
    logic [31:0] dbus_addr = 32'd0;
    logic [31:0] dbus_wdata = 32'd0;
    logic [3:0]  dbus_wmask = 4'd0;
    logic        dbus_we = 1'b0;
    logic        dbus_cyc = 1'b0;
    logic [31:0] dbus_rdata;
    logic        dbus_ack;
    cic_config_t cfg = '0;
    cic_report_t report;
    logic        n64_reset = 1'b0;
    logic        n64_cic_clk = 1'b0;
    logic        n64_si_clk = 1'b0;
    logic        dq_pull_low = 1'b0;
    wire         n64_cic_dq;
    logic        chk_req = 1'b0;
    logic [2:0]  chk_kind = 3'd0;
    logic [31:0] chk_value = 32'd0;
    int          value_errors;
    int          checker_timeouts;
    int          bus_timeouts = 0;
    logic [31:0] model [RAM_WORDS];
    step_t       steps [$];

    pullup (n64_cic_dq);
    assign n64_cic_dq = dq_pull_low ? 1'b0 : 1'bz; // console side open drain

    always #50 clk = ~clk;

    cic_core uut (
        .clk(clk), .reset(reset),
        .i_ibus_addr(ibus_addr), .i_ibus_cyc(ibus_cyc),
        .o_ibus_rdata(ibus_rdata), .o_ibus_ack(ibus_ack),
        .i_dbus_addr(dbus_addr), .i_dbus_wdata(dbus_wdata), .i_dbus_wmask(dbus_wmask),
        .i_dbus_we(dbus_we), .i_dbus_cyc(dbus_cyc),
        .o_dbus_rdata(dbus_rdata), .o_dbus_ack(dbus_ack),
        .i_config(cfg), .o_report(report),
        .i_n64_reset(n64_reset), .i_n64_cic_clk(n64_cic_clk),
        .i_n64_si_clk(n64_si_clk), .io_n64_cic_dq(n64_cic_dq)
    );

    cic_checker u_checker (
        .clk(clk),
        .i_ibus_ack(ibus_ack), .i_ibus_rdata(ibus_rdata),
        .i_dbus_ack(dbus_ack), .i_dbus_rdata(dbus_rdata),
        .i_report(report), .i_dq(n64_cic_dq),
        .i_chk_req(chk_req), .i_chk_kind(chk_kind), .i_chk_value(chk_value),
        .o_value_errors(value_errors), .o_timeouts(checker_timeouts)
    );

    function automatic void add_step(input op_t op, input logic [31:0] addr,
                                     input logic [31:0] data, input logic [3:0] mask,
                                     input logic [3:0] pins, input logic [31:0] exp_value);
        step_t s;
        s.op        = op;
        s.addr      = addr;
        s.data      = data;
        s.mask      = mask;
        s.pins      = pins;
        s.exp_value = exp_value;
        steps.push_back(s);
    endfunction

    function automatic logic [31:0] ram_addr(input int w);
        logic [31:0] a;
        a = {REGION_RAM, 19'd0, w[RAM_AW-1:0], 2'b00};
        return a;
    endfunction

    function automatic logic [31:0] reg_addr(input logic [1:0] offset);
        return {REGION_REG, 26'd0, offset, 2'b00};
    endfunction

    // {elapsed, reset, clk, dq}, line low if either side pulls it
    function automatic logic [31:0] ctrl_status(input logic [3:0] p, input logic dq_out,
                                                input logic elapsed);
        logic level;
        level = !(p[1] || !dq_out);
        return {28'd0, elapsed, p[3], p[2], level};
    endfunction

    task automatic build_table();
        logic [31:0] wdata;
        logic [31:0] rnd;
        logic [3:0]  wmask;
        int          w;
        // memory, full word then a partial byte mask
        for (int i = 0; i < 8; i++) begin
            w     = (i * 61 + 7) % RAM_WORDS;
            wdata = $urandom;
            add_step(OP_WRITE, ram_addr(w), wdata, 4'hf, 4'h0, 32'd0);
            model[w] = wdata;
            wdata = $urandom;
            rnd   = $urandom_range(14, 1);
            wmask = rnd[3:0];
            add_step(OP_WRITE, ram_addr(w), wdata, wmask, 4'h0, 32'd0);
            for (int b = 0; b < 4; b++) begin
                if (wmask[b]) model[w][8*b +: 8] = wdata[8*b +: 8];
            end
        end
        for (int i = 0; i < 8; i++) begin
            w = (i * 61 + 7) % RAM_WORDS;
            add_step(OP_READ, ram_addr(w), 32'd0, 4'h0, 4'h0, model[w]);
            add_step(OP_IREAD, ram_addr(w), 32'd0, 4'h0, 4'h0, model[w]);
        end
        // configuration words
        add_step(OP_READ, reg_addr(REG_CFG0), 32'd0, 4'h0, 4'h0,
                 {5'd0, cfg.disabled, cfg.dd_mode, cfg.region, cfg.seed, cfg.checksum[47:32]});
        add_step(OP_READ, reg_addr(REG_CFG1), 32'd0, 4'h0, 4'h0, cfg.checksum[31:0]);
        // pin status
        add_step(OP_PINS, 32'd0, 32'd0, 4'h0, 4'b1100, 32'd0);
        add_step(OP_WAIT, 32'd0, 32'd3, 4'h0, 4'h0, 32'd0);
        add_step(OP_READ, reg_addr(REG_CTRL), 32'd0, 4'h0, 4'h0, ctrl_status(4'b1100, 1, 0));
        add_step(OP_PINS, 32'd0, 32'd0, 4'h0, 4'b1010, 32'd0);
        add_step(OP_WAIT, 32'd0, 32'd3, 4'h0, 4'h0, 32'd0);
        add_step(OP_READ, reg_addr(REG_CTRL), 32'd0, 4'h0, 4'h0, ctrl_status(4'b1010, 1, 0));
        add_step(OP_PINS, 32'd0, 32'd0, 4'h0, 4'b1000, 32'd0);
        add_step(OP_WAIT, 32'd0, 32'd3, 4'h0, 4'h0, 32'd0);
        // data line driver
        add_step(OP_WRITE, reg_addr(REG_CTRL), 32'h0, 4'hf, 4'h0, 32'd0);
        add_step(OP_WAIT, 32'd0, 32'd3, 4'h0, 4'h0, 32'd0);
        add_step(OP_CHECK, 32'd0, 32'd3, 4'h0, 4'h0, 32'd0);
        add_step(OP_READ, reg_addr(REG_CTRL), 32'd0, 4'h0, 4'h0, ctrl_status(4'b1000, 0, 0));
        add_step(OP_WRITE, reg_addr(REG_CTRL), 32'h1, 4'hf, 4'h0, 32'd0);
        add_step(OP_WAIT, 32'd0, 32'd3, 4'h0, 4'h0, 32'd0);
        add_step(OP_CHECK, 32'd0, 32'd3, 4'h0, 4'h0, 32'd1);
        add_step(OP_WRITE, reg_addr(REG_CTRL), 32'h0, 4'hf, 4'h0, 32'd0);
        add_step(OP_WAIT, 32'd0, 32'd3, 4'h0, 4'h0, 32'd0);
        add_step(OP_CHECK, 32'd0, 32'd3, 4'h0, 4'h0, 32'd0);
        add_step(OP_PINS, 32'd0, 32'd0, 4'h0, 4'b0000, 32'd0); // console reset releases
        add_step(OP_WAIT, 32'd0, 32'd5, 4'h0, 4'h0, 32'd0);
        add_step(OP_CHECK, 32'd0, 32'd3, 4'h0, 4'h0, 32'd1);
        add_step(OP_READ, reg_addr(REG_CTRL), 32'd0, 4'h0, 4'h0, ctrl_status(4'b0000, 1, 0));
        add_step(OP_PINS, 32'd0, 32'd0, 4'h0, 4'b1000, 32'd0);
        add_step(OP_WAIT, 32'd0, 32'd3, 4'h0, 4'h0, 32'd0);
        // timer, 256 x 3815 qualified edges in all
        add_step(OP_WRITE, reg_addr(REG_CTRL), 32'h11, 4'hf, 4'h0, 32'd0);
        add_step(OP_EDGES, 32'd0, 32'd1000, 4'h0, 4'h0, 32'd0);
        add_step(OP_PINS, 32'd0, 32'd0, 4'h0, 4'b0000, 32'd0);
        add_step(OP_WAIT, 32'd0, 32'd3, 4'h0, 4'h0, 32'd0);
        add_step(OP_EDGES, 32'd0, 32'd300, 4'h0, 4'h0, 32'd0); // not counted
        add_step(OP_PINS, 32'd0, 32'd0, 4'h0, 4'b1000, 32'd0);
        add_step(OP_WAIT, 32'd0, 32'd3, 4'h0, 4'h0, 32'd0);
        add_step(OP_EDGES, 32'd0, 32'd975639, 4'h0, 4'h0, 32'd0);
        add_step(OP_WAIT, 32'd0, 32'd4, 4'h0, 4'h0, 32'd0);
        add_step(OP_READ, reg_addr(REG_CTRL), 32'd0, 4'h0, 4'h0, ctrl_status(4'b1000, 1, 0));
        add_step(OP_EDGES, 32'd0, 32'd1, 4'h0, 4'h0, 32'd0);
        add_step(OP_WAIT, 32'd0, 32'd4, 4'h0, 4'h0, 32'd0);
        add_step(OP_READ, reg_addr(REG_CTRL), 32'd0, 4'h0, 4'h0, ctrl_status(4'b1000, 1, 1));
        add_step(OP_WRITE, reg_addr(REG_CTRL), 32'h21, 4'hf, 4'h0, 32'd0);
        add_step(OP_WAIT, 32'd0, 32'd2, 4'h0, 4'h0, 32'd0);
        add_step(OP_READ, reg_addr(REG_CTRL), 32'd0, 4'h0, 4'h0, ctrl_status(4'b1000, 1, 0));
        // report
        add_step(OP_WRITE, reg_addr(REG_CTRL), 32'h41, 4'hf, 4'h0, 32'd0);
        add_step(OP_WAIT, 32'd0, 32'd2, 4'h0, 4'h0, 32'd0);
        add_step(OP_CHECK, 32'd0, 32'd5, 4'h0, 4'h0, 32'd1);
        add_step(OP_WRITE, reg_addr(REG_DEBUG), 32'ha, 4'hf, 4'h0, 32'd0);
        add_step(OP_WAIT, 32'd0, 32'd2, 4'h0, 4'h0, 32'd0);
        add_step(OP_CHECK, 32'd0, 32'd4, 4'h0, 4'h0, 32'ha);
        // line pulled low so that reset has to release it
        add_step(OP_WRITE, reg_addr(REG_CTRL), 32'h0, 4'hf, 4'h0, 32'd0);
        add_step(OP_WAIT, 32'd0, 32'd3, 4'h0, 4'h0, 32'd0);
        add_step(OP_CHECK, 32'd0, 32'd3, 4'h0, 4'h0, 32'd0);
        add_step(OP_RESET, 32'd0, 32'd0, 4'h0, 4'h0, 32'd0);
        add_step(OP_CHECK, 32'd0, 32'd4, 4'h0, 4'h0, 32'd0);
        add_step(OP_CHECK, 32'd0, 32'd3, 4'h0, 4'h0, 32'd1);
        add_step(OP_CHECK, 32'd0, 32'd5, 4'h0, 4'h0, 32'd1);
    endtask

    task automatic wait_dbus_ack();
        int count;
        count = 0;
        while (count < 20) begin
            @(negedge clk);
            chk_req = 1'b0;
            if (dbus_ack) break;
            count++;
        end
        if (count >= 20) begin
            bus_timeouts++;
            $display("data bus gave no acknowledge for address %h", dbus_addr);
        end
        dbus_cyc = 1'b0;
        dbus_we  = 1'b0;
    endtask

    task automatic dbus_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] mask);
        @(negedge clk);
        dbus_addr  = addr;
        dbus_wdata = data;
        dbus_wmask = mask;
        dbus_we    = 1'b1;
        dbus_cyc   = 1'b1;
        wait_dbus_ack();
    endtask

    task automatic dbus_read(input logic [31:0] addr, input logic [31:0] exp_value);
        @(negedge clk);
        dbus_addr = addr;
        dbus_we   = 1'b0;
        dbus_cyc  = 1'b1;
        chk_req   = 1'b1; // checker compares in the ack cycle
        chk_kind  = 3'd1;
        chk_value = exp_value;
        wait_dbus_ack();
    endtask

    task automatic ibus_read(input logic [31:0] addr, input logic [31:0] exp_value);
        int count;
        @(negedge clk);
        ibus_addr = addr;
        ibus_cyc  = 1'b1;
        chk_req   = 1'b1;
        chk_kind  = 3'd2;
        chk_value = exp_value;
        count     = 0;
        while (count < 20) begin
            @(negedge clk);
            chk_req = 1'b0;
            if (ibus_ack) break;
            count++;
        end
        if (count >= 20) begin
            bus_timeouts++;
            $display("instruction bus gave no acknowledge for address %h", addr);
        end
        ibus_cyc = 1'b0;
    endtask

    task automatic set_pins(input logic [3:0] pins);
        @(negedge clk);
        n64_reset   = pins[3];
        n64_cic_clk = pins[2];
        dq_pull_low = pins[1];
        n64_si_clk  = pins[0];
    endtask

    task automatic si_edges(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            n64_si_clk = 1'b1;
            @(negedge clk);
            n64_si_clk = 1'b0;
        end
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
        end
    endtask

    task automatic request_check(input logic [2:0] kind, input logic [31:0] exp_value);
        @(negedge clk);
        chk_req   = 1'b1;
        chk_kind  = kind;
        chk_value = exp_value;
        @(negedge clk);
        chk_req = 1'b0;
    endtask

    task automatic pulse_reset();
        @(negedge clk);
        reset = 1'b1;
        idle_cycles(2);
        reset = 1'b0;
    endtask

    // hard limit on simulated time
    initial begin
        #600_000_000;
        $display("simulation ran past its time limit");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        logic [31:0] rnd;
        void'($urandom(32'h1641_175c));
        rnd              = $urandom;
        cfg.disabled     = rnd[0];
        cfg.dd_mode      = rnd[1];
        cfg.region       = rnd[2];
        cfg.seed         = rnd[15:8];
        cfg.checksum[47:32] = rnd[31:16];
        cfg.checksum[31:0]  = $urandom;
        build_table();
        idle_cycles(2);
        reset = 1'b0;
        foreach (steps[i]) begin
            case (steps[i].op)
                OP_WRITE: dbus_write(steps[i].addr, steps[i].data, steps[i].mask);
                OP_READ:  dbus_read(steps[i].addr, steps[i].exp_value);
                OP_IREAD: ibus_read(steps[i].addr, steps[i].exp_value);
                OP_PINS:  set_pins(steps[i].pins);
                OP_EDGES: si_edges(int'(steps[i].data));
                OP_WAIT:  idle_cycles(int'(steps[i].data));
                OP_CHECK: request_check(steps[i].data[2:0], steps[i].exp_value);
                default:  pulse_reset();
            endcase
        end
        idle_cycles(40); // lets a pending checker timeout expire
        $display("errors: %0d value, %0d checker timeout, %0d bus timeout",
                 value_errors, checker_timeouts, bus_timeouts);
        if (value_errors == 0 && checker_timeouts == 0 && bus_timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- testbench/cic_checker.sv
`timescale 1ns/100ps

module cic_checker (
    input  logic                 clk,
    input  logic                 i_ibus_ack,
    input  logic [31:0]          i_ibus_rdata,
    input  logic                 i_dbus_ack,
    input  logic [31:0]          i_dbus_rdata,
    input  cic_pkg::cic_report_t i_report,
    input  logic                 i_dq,
    input  logic                 i_chk_req,
    input  logic [2:0]           i_chk_kind,
    input  logic [31:0]          i_chk_value,
    output int                   o_value_errors,
    output int                   o_timeouts
);

    import cic_pkg::*;

    int          value_errors = 0;
    int          timeouts = 0;
    int          pulses = 0;
    int          pend_age = 0;
    logic [2:0]  pend_kind = 3'd0; // 1 dbus read, 2 ibus read
    logic [31:0] pend_value = 32'd0;
    logic        last_dbus_ack = 1'b0;
    logic        last_ibus_ack = 1'b0;
    logic        last_invalid = 1'b0;

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp_value);
        if (got !== exp_value) begin
            value_errors++;
            $display("error %0t: %s is %h, expected %h", $time, what, got, exp_value);
        end
    endtask

    // outputs sampled just before each rising edge
    always @(posedge clk) begin
        if (i_dbus_ack && last_dbus_ack) begin
            value_errors++;
            $display("error %0t: data bus ack held longer than one cycle", $time);
        end
        if (i_ibus_ack && last_ibus_ack) begin
            value_errors++;
            $display("error %0t: instruction bus ack held longer than one cycle", $time);
        end
        if (i_report.invalid_region) begin
            pulses++;
            if (last_invalid) begin
                value_errors++;
                $display("error %0t: invalid_region pulse longer than one cycle", $time);
            end
        end
        last_dbus_ack = i_dbus_ack;
        last_ibus_ack = i_ibus_ack;
        last_invalid  = i_report.invalid_region;

        if (pend_kind == 3'd1 && i_dbus_ack) begin
            compare_value("data bus read", i_dbus_rdata, pend_value);
            pend_kind = 3'd0;
        end else if (pend_kind == 3'd2 && i_ibus_ack) begin
            compare_value("instruction read", i_ibus_rdata, pend_value);
            pend_kind = 3'd0;
        end else if (pend_kind != 3'd0) begin
            pend_age++;
            if (pend_age > 32) begin
                timeouts++;
                $display("checker gave up waiting for a read acknowledge at %0t", $time);
                pend_kind = 3'd0;
            end
        end

        if (i_chk_req) begin
            case (i_chk_kind)
                3'd1, 3'd2: begin
                    pend_kind  = i_chk_kind;
                    pend_value = i_chk_value;
                    pend_age   = 0;
                end
                3'd3: compare_value("data line", {31'd0, i_dq}, i_chk_value);
                3'd4: compare_value("debug step", {28'd0, i_report.debug_step}, i_chk_value);
                default: compare_value("invalid_region pulses", pulses, i_chk_value);
            endcase
        end
    end

    assign o_value_errors = value_errors;
    assign o_timeouts     = timeouts;

endmodule

//--- cic/cic_core.sv
`timescale 1ns/100ps

module cic_core (
    input  logic                 clk,
    input  logic                 reset,

    input  logic [31:0]          i_ibus_addr,
    input  logic                 i_ibus_cyc,
    output logic [31:0]          o_ibus_rdata,
    output logic                 o_ibus_ack,

    input  logic [31:0]          i_dbus_addr,
    input  logic [31:0]          i_dbus_wdata,
    input  logic [3:0]           i_dbus_wmask,
    input  logic                 i_dbus_we,
    input  logic                 i_dbus_cyc,
    output logic [31:0]          o_dbus_rdata,
    output logic                 o_dbus_ack,

    input  cic_pkg::cic_config_t i_config,
    output cic_pkg::cic_report_t o_report,

    input  logic                 i_n64_reset,
    input  logic                 i_n64_cic_clk,
    input  logic                 i_n64_si_clk,
    inout  wire                  io_n64_cic_dq
);

    import cic_pkg::*;

    cic_pins_t   pins;
    logic        si_rise;
    logic        dq_low;
    logic        timer_start;
    logic        timer_clear;
    logic        timer_elapsed;
    logic        ram_we;
    logic [3:0]  ram_wmask;
    logic [31:0] ram_rdata;

    assign o_ibus_rdata = ram_rdata; // shared read port

    cic_pin_sync u_pin_sync (
        .clk           (clk),
        .reset         (reset),
        .i_n64_reset   (i_n64_reset),
        .i_n64_cic_clk (i_n64_cic_clk),
        .i_n64_si_clk  (i_n64_si_clk),
        .i_dq_low      (dq_low),
        .io_n64_cic_dq (io_n64_cic_dq),
        .o_pins        (pins),
        .o_si_rise     (si_rise)
    );

    cic_timer u_timer (
        .clk       (clk),
        .reset     (reset),
        .i_si_rise (si_rise),
        .i_start   (timer_start),
        .i_clear   (timer_clear),
        .o_elapsed (timer_elapsed)
    );

    cic_ram u_ram (
        .clk         (clk),
        .i_ibus_addr (i_ibus_addr),
        .i_ibus_cyc  (i_ibus_cyc),
        .i_dbus_addr (i_dbus_addr),
        .i_we        (ram_we),
        .i_wmask     (ram_wmask),
        .i_wdata     (i_dbus_wdata),
        .o_rdata     (ram_rdata),
        .o_ibus_ack  (o_ibus_ack)
    );

    cic_regs u_regs (
        .clk           (clk),
        .reset         (reset),
        .i_dbus_addr   (i_dbus_addr),
        .i_dbus_wdata  (i_dbus_wdata),
        .i_dbus_wmask  (i_dbus_wmask),
        .i_dbus_we     (i_dbus_we),
        .i_dbus_cyc    (i_dbus_cyc),
        .i_config      (i_config),
        .i_pins        (pins),
        .i_elapsed     (timer_elapsed),
        .i_ram_rdata   (ram_rdata),
        .o_dbus_rdata  (o_dbus_rdata),
        .o_dbus_ack    (o_dbus_ack),
        .o_ram_we      (ram_we),
        .o_ram_wmask   (ram_wmask),
        .o_dq_low      (dq_low),
        .o_timer_start (timer_start),
        .o_timer_clear (timer_clear),
        .o_report      (o_report)
    );

endmodule

//--- cic/cic_regs.sv
`timescale 1ns/100ps

module cic_regs (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [31:0]          i_dbus_addr,
    input  logic [31:0]          i_dbus_wdata,
    input  logic [3:0]           i_dbus_wmask,
    input  logic                 i_dbus_we,
    input  logic                 i_dbus_cyc,
    input  cic_pkg::cic_config_t i_config,
    input  cic_pkg::cic_pins_t   i_pins,
    input  logic                 i_elapsed,
    input  logic [31:0]          i_ram_rdata,
    output logic [31:0]          o_dbus_rdata,
    output logic                 o_dbus_ack,
    output logic                 o_ram_we,
    output logic [3:0]           o_ram_wmask,
    output logic                 o_dq_low,
    output logic                 o_timer_start,
    output logic                 o_timer_clear,
    output cic_pkg::cic_report_t o_report
);

    import cic_pkg::*;

    logic [1:0]  region;
    logic [1:0]  offset;
    logic        wr_en;
    logic        ctrl_wr;
    logic        dbus_ack;
    logic        dq_out;
    logic        timer_start;
    logic        timer_clear;
    cic_report_t report_q;

    assign region  = i_dbus_addr[31:30];
    assign offset  = i_dbus_addr[3:2];
    assign wr_en   = i_dbus_cyc && i_dbus_we && !dbus_ack; // first cycle only
    assign ctrl_wr = wr_en && region == REGION_REG && offset == REG_CTRL;

    assign o_ram_we    = wr_en && region == REGION_RAM;
    assign o_ram_wmask = i_dbus_wmask;

    always_ff @(posedge clk) begin
        if (reset) begin
            dbus_ack    <= 1'b0;
            timer_start <= 1'b0;
            timer_clear <= 1'b0;
            report_q    <= '0;
        end else begin
            dbus_ack                <= i_dbus_cyc && !dbus_ack;
            timer_start             <= 1'b0;
            timer_clear             <= 1'b0;
            report_q.invalid_region <= 1'b0;
            if (ctrl_wr) begin
                report_q.invalid_region <= i_dbus_wdata[6];
                timer_clear             <= i_dbus_wdata[5];
                timer_start             <= i_dbus_wdata[4];
            end
            if (wr_en && region == REGION_REG && offset == REG_DEBUG) begin
                report_q.debug_step <= i_dbus_wdata[3:0];
            end
        end
    end

    // console in reset releases the line
    always_ff @(posedge clk) begin
        if (reset || !i_pins.reset) begin
            dq_out <= 1'b1;
        end else if (ctrl_wr) begin
            dq_out <= i_dbus_wdata[0];
        end
    end

    always_comb begin
        o_dbus_rdata = 32'd0;
        if (region == REGION_RAM) begin
            o_dbus_rdata = i_ram_rdata;
        end else if (region == REGION_REG) begin
            case (offset)
                REG_CFG0: o_dbus_rdata = {5'd0, i_config.disabled, i_config.dd_mode,
                                          i_config.region, i_config.seed,
                                          i_config.checksum[47:32]};
                REG_CFG1: o_dbus_rdata = i_config.checksum[31:0];
                REG_CTRL: o_dbus_rdata = {28'd0, i_elapsed, i_pins.reset, i_pins.clk,
                                          i_pins.dq};
                default:  o_dbus_rdata = {28'd0, report_q.debug_step};
            endcase
        end
    end

    assign o_dbus_ack    = dbus_ack;
    assign o_dq_low      = ~dq_out;
    assign o_timer_start = timer_start;
    assign o_timer_clear = timer_clear;
    assign o_report      = report_q;

endmodule

//--- cic/cic_ram.sv
`timescale 1ns/100ps

module cic_ram (
    input  logic        clk,
    input  logic [31:0] i_ibus_addr,
    input  logic        i_ibus_cyc,
    input  logic [31:0] i_dbus_addr,
    input  logic        i_we,
    input  logic [3:0]  i_wmask,
    input  logic [31:0] i_wdata,
    output logic [31:0] o_rdata,
    output logic        o_ibus_ack
);

    import cic_pkg::*;

    logic [31:0]       mem [RAM_WORDS];
    logic [RAM_AW-1:0] addr;
    logic [31:0]       rdata;
    logic              ibus_ack;

    // instruction fetch wins the port
    assign addr = i_ibus_cyc ? i_ibus_addr[RAM_AW+1:2] : i_dbus_addr[RAM_AW+1:2];

    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (i_we && i_wmask[b]) begin
                mem[addr][8*b +: 8] <= i_wdata[8*b +: 8]; // byte lane
            end
        end
    end

    // single pulse, never back to back
    always_ff @(posedge clk) begin
        ibus_ack <= i_ibus_cyc && !ibus_ack;
    end

    assign o_rdata    = rdata;
    assign o_ibus_ack = ibus_ack;

endmodule

//--- cic/cic_timer.sv
`timescale 1ns/100ps

module cic_timer (
    input  logic clk,
    input  logic reset,
    input  logic i_si_rise,
    input  logic i_start,
    input  logic i_clear,
    output logic o_elapsed
);

    import cic_pkg::*;

    logic [PRESCALE_BITS-1:0] prescale;
    logic [TIMER_BITS-1:0]    counter;
    logic                     elapsed;
    logic                     wrap;

    // prescaler about to roll over on this edge
    assign wrap = i_si_rise && (&prescale);

    always_ff @(posedge clk) begin
        if (reset || i_clear) begin
            prescale <= '0;
            counter  <= '0;
            elapsed  <= 1'b0;
        end else if (i_start) begin
            prescale <= '0;
            counter  <= TIMEOUT_TICKS; // reload full timeout
            elapsed  <= 1'b0;
        end else begin
            if (i_si_rise) begin
                prescale <= prescale + 1'b1;
            end
            if (wrap && counter != '0) begin
                counter <= counter - 1'b1;
                if (counter == TIMER_BITS'(1)) begin
                    elapsed <= 1'b1; // last tick
                end
            end
        end
    end

    assign o_elapsed = elapsed;

endmodule

//--- src/cic_pin_sync.sv
`timescale 1ns/100ps

module cic_pin_sync (
    input  logic              clk,
    input  logic              reset,
    input  logic              i_n64_reset,
    input  logic              i_n64_cic_clk,
    input  logic              i_n64_si_clk,
    input  logic              i_dq_low,
    inout  wire               io_n64_cic_dq,
    output cic_pkg::cic_pins_t o_pins,
    output logic              o_si_rise
);

    import cic_pkg::*;

    cic_pins_t pins_meta; // first stage
    cic_pins_t pins_sync; // second stage
    logic      last_si_clk;
    logic      dq_oe;

    always_ff @(posedge clk) begin
        if (reset) begin
            pins_meta   <= '0;
            pins_sync   <= '0;
            last_si_clk <= 1'b0;
        end else begin
            pins_meta.reset  <= i_n64_reset;
            pins_meta.clk    <= i_n64_cic_clk;
            pins_meta.dq     <= io_n64_cic_dq;
            pins_meta.si_clk <= i_n64_si_clk;
            pins_sync        <= pins_meta;
            last_si_clk      <= pins_sync.si_clk;
        end
    end

    // edges only count while the console is out of reset
    assign o_si_rise = pins_sync.reset && !last_si_clk && pins_sync.si_clk;
    assign o_pins    = pins_sync;

    always_ff @(posedge clk) begin
        if (reset) begin
            dq_oe <= 1'b0; // line released
        end else begin
            dq_oe <= i_dq_low;
        end
    end

    assign io_n64_cic_dq = dq_oe ? 1'b0 : 1'bz; // open drain

endmodule

//--- common/cic_pkg.sv
package cic_pkg;

    // cartridge configuration from the system controller
    typedef struct packed {
        logic        disabled;
        logic        dd_mode;
        logic        region;
        logic [7:0]  seed;
        logic [47:0] checksum;
    } cic_config_t;

    // values firmware reports back to the system controller
    typedef struct packed {
        logic       invalid_region; // one-cycle pulse
        logic [3:0] debug_step;
    } cic_report_t;

    // synchronized console pin levels
    typedef struct packed {
        logic reset;
        logic clk;
        logic dq;
        logic si_clk;
    } cic_pins_t;

    // program/data memory
    localparam int RAM_WORDS = 512;
    localparam int RAM_AW    = 9;

    // timeout timer, about 500 ms of serial clock
    localparam int                    PRESCALE_BITS = 8;
    localparam int                    TIMER_BITS    = 12;
    localparam logic [TIMER_BITS-1:0] TIMEOUT_TICKS = 12'd3815;

    // address bits 31:30
    localparam logic [1:0] REGION_RAM = 2'b10;
    localparam logic [1:0] REGION_REG = 2'b11;

    // register word offsets, address bits 3:2
    localparam logic [1:0] REG_CFG0  = 2'd0;
    localparam logic [1:0] REG_CFG1  = 2'd1;
    localparam logic [1:0] REG_CTRL  = 2'd2;
    localparam logic [1:0] REG_DEBUG = 2'd3;

endpackage
